// ==== all.f ====
+incdir+src
+incdir+tests
src/pcpu_isa_pkg.sv
src/pcpu_pipe_pkg.sv
src/pcpu_decode.sv
src/pcpu_alu.sv
src/pcpu_regfile.sv
src/pcpu_hazard.sv
src/pcpu_core.sv
tests/tb_pcpu.sv

// ==== Makefile ====
# Verilator build and run for the pcpu testbench

VERILATOR ?= verilator
TOP       ?= tb_pcpu
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh tests/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@grep -qx 'Test OK' $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_pcpu_model.svh ====
// pcpu reference interpreter
`ifndef TB_PCPU_MODEL_SVH
`define TB_PCPU_MODEL_SVH

logic [`PCPU_XLEN-1:0]   m_regs [32];
logic [`PCPU_XLEN-1:0]   m_dmem [16];
logic [2*`PCPU_XLEN-1:0] m_stores [$];   // {addr, data} in program order

// initial data memory contents, every address bit matters
function automatic logic [31:0] fill_word(input int a);
    return $unsigned(a) * 32'h9e37_79b9 ^ 32'h00c0_ffee;
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
                                      input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'h00, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// executes prog in order until pc reaches the halt loop
task automatic run_model(input int halt);
    int          pc;
    int          steps;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] res;
    logic [4:0]  dst;
    logic        wr;
    for (steps = 0; steps < 32; steps++)
        m_regs[steps] = '0;
    for (steps = 0; steps < 16; steps++)
        m_dmem[steps] = fill_word(steps);
    m_stores.delete();
    pc    = 0;
    steps = 0;
    while (pc != halt && steps < 1000) begin
        ins   = prog[pc];
        a     = m_regs[ins[25:21]];
        b     = m_regs[ins[20:16]];
        imm   = {{16{ins[15]}}, ins[15:0]};
        addr  = a + imm;
        dst   = ins[20:16];
        wr    = 1'b1;
        res   = '0;
        pc    = pc + 1;  // no delay slot
        steps = steps + 1;
        case (ins[31:26])
            pcpu_isa_pkg::OP_RTYPE: begin
                dst = ins[15:11];
                case (ins[5:0])
                    pcpu_isa_pkg::FN_ADDU: res = a + b;
                    pcpu_isa_pkg::FN_SUBU: res = a - b;
                    pcpu_isa_pkg::FN_AND:  res = a & b;
                    pcpu_isa_pkg::FN_OR:   res = a | b;
                    pcpu_isa_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:               wr = 1'b0;
                endcase
            end
            pcpu_isa_pkg::OP_ADDIU: res = addr;
            pcpu_isa_pkg::OP_LUI:   res = {ins[15:0], 16'h0000};
            pcpu_isa_pkg::OP_LW:    res = m_dmem[addr[3:0]];
            pcpu_isa_pkg::OP_SW: begin
                wr = 1'b0;
                m_dmem[addr[3:0]] = b;
                m_stores.push_back({addr, b});
            end
            pcpu_isa_pkg::OP_BEQ: begin
                wr = 1'b0;
                if (a == b)
                    pc = pc + $signed(imm);
            end
            pcpu_isa_pkg::OP_BNE: begin
                wr = 1'b0;
                if (a != b)
                    pc = pc + $signed(imm);
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0)
            m_regs[dst] = res;  // writes to $0 are dropped
    end
endtask

`endif

// ==== tests/tb_pcpu.sv ====
// pcpu pipeline testbench
`timescale 1ns/10ps
`default_nettype none
`include "pcpu_cfg.svh"

module tb_pcpu;

    localparam int HALT        = 47;  // address of the final beq to itself
    localparam int KIND_ALU    = 0;
    localparam int KIND_LOAD   = 1;
    localparam int KIND_BRANCH = 2;
    localparam int KIND_STORE  = 3;
    localparam int KIND_MIX    = 4;

    logic                     clk;
    logic                     arst_n;
    logic [`PCPU_RADDR_W-1:0] reg_addr;
    logic [`PCPU_XLEN-1:0]    reg_data;
    logic [`PCPU_XLEN-1:0]    im_addr;
    logic [`PCPU_XLEN-1:0]    im_data;
    logic [`PCPU_XLEN-1:0]    dm_addr;
    logic                     dm_we;
    logic [`PCPU_XLEN-1:0]    dm_wdata;
    logic [`PCPU_XLEN-1:0]    dm_rdata;

    logic [`PCPU_XLEN-1:0]    prog [64];
    logic [`PCPU_XLEN-1:0]    dmem [16];
    logic                     mem_init;
    integer                   seed = 32'hb09c8529;
    int                       store_idx;
    int                       store_err;
    int                       n_pass;
    int                       n_fail;

    `include "tb_pcpu_model.svh"

    pcpu_core u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // **************************************************
    // memories and store monitor
    // **************************************************

    assign im_data  = prog[im_addr[5:0]];  // async read
    assign dm_rdata = dmem[dm_addr[3:0]];

    always @(posedge clk) begin
        if (mem_init) begin
            for (int i = 0; i < 16; i++)
                dmem[i] <= fill_word(i);
        end else if (dm_we) begin
            dmem[dm_addr[3:0]] <= dm_wdata;
        end
    end

    always @(negedge clk) begin
        logic [2*`PCPU_XLEN-1:0] exp_st;
        if (!arst_n) begin
            store_idx = 0;
            store_err = 0;
        end else if (dm_we) begin
            if (store_idx >= m_stores.size()) begin
                $display("store to dm_addr %h beyond the end of the expected list", dm_addr);
                store_err++;
            end else begin
                exp_st = m_stores[store_idx];
                if (dm_addr !== exp_st[63:32]) begin
                    $display("Mismatch dm_addr expected %h got %h", exp_st[63:32], dm_addr);
                    store_err++;
                end
                if (dm_wdata !== exp_st[31:0]) begin
                    $display("Mismatch dm_wdata expected %h got %h", exp_st[31:0], dm_wdata);
                    store_err++;
                end
                store_idx++;
            end
        end
    end

    // **************************************************
    // program generator
    // **************************************************

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand32() % n);
    endfunction

    function automatic logic [4:0] rand_reg(input bit allow_zero);
        int n;
        n = rand_below(allow_zero ? 8 : 7);
        return allow_zero ? 5'(n) : 5'(n + 1);
    endfunction

    function automatic logic [5:0] pick_funct();
        case (rand_below(5))
            0:       return pcpu_isa_pkg::FN_ADDU;
            1:       return pcpu_isa_pkg::FN_SUBU;
            2:       return pcpu_isa_pkg::FN_AND;
            3:       return pcpu_isa_pkg::FN_OR;
            default: return pcpu_isa_pkg::FN_SLT;
        endcase
    endfunction

    // 0 rtype, 1 addiu, 2 lui, 3 lw, 4 sw, 5 branch
    function automatic int pick_class(input int kind, input int prev, input int pos);
        int n;
        n = rand_below(6);
        case (kind)
            KIND_ALU:    return n % 3;
            KIND_LOAD:   return (prev == 3) ? 0 : (n < 3) ? 3 : (n == 3) ? 4 : n - 4;
            KIND_BRANCH: return (pos >= HALT - 3) ? n % 2 : (n < 2) ? n : (n == 2) ? 3 : 5;
            KIND_STORE:  return (n < 2) ? n : (n == 2) ? 3 : 4;
            default:     return (n == 5 && pos >= HALT - 3) ? 0 : n;
        endcase
    endfunction

    task automatic gen_program(input int kind);
        int          i;
        int          cls;
        int          prev;
        logic [4:0]  d;
        logic [4:0]  s;
        logic [4:0]  t;
        logic [4:0]  last;
        logic [31:0] r;
        for (i = 0; i < 64; i++)
            prog[i] = '0;
        for (i = 0; i < 7; i++) begin  // give $1..$7 known values
            r       = rand32();
            prog[i] = enc_i(pcpu_isa_pkg::OP_ADDIU, 5'd0, 5'(i + 1), r[15:0]);
        end
        last = 5'd7;
        prev = 1;
        for (i = 7; i < HALT; i++) begin
            cls = pick_class(kind, prev, i);
            r   = rand32();
            s   = (r[16] || prev == 3) ? last : rand_reg(kind == KIND_MIX);
            t   = rand_reg(1'b0);
            d   = rand_reg(kind == KIND_MIX);  // mix also targets $0
            case (cls)
                0: prog[i] = enc_r(pick_funct(), d, s, t);
                1: prog[i] = enc_i(pcpu_isa_pkg::OP_ADDIU, s, d, {{14{r[1]}}, r[1:0]});
                2: prog[i] = enc_i(pcpu_isa_pkg::OP_LUI, 5'd0, d, r[15:0]);
                3: prog[i] = enc_i(pcpu_isa_pkg::OP_LW, 5'd0, d, {12'h000, r[3:0]});
                4: prog[i] = enc_i(pcpu_isa_pkg::OP_SW, 5'd0, s, {12'h000, r[3:0]});
                default: prog[i] = enc_i(r[17] ? pcpu_isa_pkg::OP_BNE : pcpu_isa_pkg::OP_BEQ,
                                         s, r[18] ? s : t, 16'(1 + rand_below(3)));
            endcase
            if (cls <= 3)
                last = d;
            prev = cls;
        end
        prog[HALT] = enc_i(pcpu_isa_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff);
    endtask

    // **************************************************
    // run control and checks
    // **************************************************

    task automatic apply_reset();
        @(posedge clk);
        arst_n   <= 1'b0;
        mem_init <= 1'b1;
        reg_addr <= '0;
        for (int i = 0; i < 16; i++)
            @(posedge clk);
        arst_n   <= 1'b1;
        mem_init <= 1'b0;
    endtask

    // the halt loop fetches HALT and HALT+1 in turn
    task automatic wait_halt(output bit done);
        int in_loop;
        done    = 1'b0;
        in_loop = 0;
        for (int cyc = 0; cyc < 2000 && !done; cyc++) begin
            @(negedge clk);
            if (im_addr == HALT || im_addr == HALT + 1)
                in_loop++;
            else
                in_loop = 0;
            if (in_loop >= 8)
                done = 1'b1;
        end
    endtask

    task automatic read_dbg(input logic [4:0] addr, output logic [31:0] val);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        val = reg_data;
    endtask

    task automatic report(input string name, input int errs);
        if (errs == 0) begin
            $display("PASS %s", name);
            n_pass++;
        end else begin
            $display("FAIL %s (%0d errors)", name, errs);
            n_fail++;
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = 0;
        for (int i = 0; i < 64; i++)
            prog[i] = '0;
        apply_reset();
        @(negedge clk);
        if (dm_we !== 1'b0) begin
            $display("Mismatch dm_we expected 0 got %h", dm_we);
            errs++;
        end
        if (im_addr !== `PCPU_RESET_PC) begin
            $display("Mismatch im_addr expected %h got %h", `PCPU_RESET_PC, im_addr);
            errs++;
        end
        if (reg_data !== 32'h0) begin
            $display("Mismatch reg_data[0] expected %h got %h", 32'h0, reg_data);
            errs++;
        end
        report("reset state", errs);
    endtask

    task automatic run_test(input string name, input int kind);
        int          errs;
        bit          done;
        logic [31:0] val;
        errs = 0;
        gen_program(kind);
        run_model(HALT);
        apply_reset();
        wait_halt(done);
        if (!done) begin
            $display("%s: the CPU never reached the end of the program", name);
            errs++;
        end else begin
            for (int r = 1; r < 8; r++) begin
                read_dbg(5'(r), val);
                if (val !== m_regs[r]) begin
                    $display("Mismatch reg_data[%0d] expected %h got %h", r, m_regs[r], val);
                    errs++;
                end
            end
            errs += store_err;
            if (store_idx != m_stores.size()) begin
                $display("%s: %0d of %0d stores were seen", name, store_idx, m_stores.size());
                errs++;
            end
            if (kind == KIND_MIX) begin
                for (int a = 0; a < 16; a++) begin
                    if (dmem[a] !== m_dmem[a]) begin
                        $display("Mismatch dmem[%0d] expected %h got %h", a, m_dmem[a], dmem[a]);
                        errs++;
                    end
                end
                read_dbg(5'd0, val);  // debug address 0 is the pc
                if (val !== HALT && val !== HALT + 1) begin
                    $display("Mismatch reg_data[0] expected %h got %h", HALT, val);
                    errs++;
                end
            end
        end
        report(name, errs);
    endtask

    initial begin
        arst_n   = 1'b0;
        reg_addr = '0;
        mem_init = 1'b0;
        n_pass   = 0;
        n_fail   = 0;
        test_reset();
        run_test("alu dependencies", KIND_ALU);
        run_test("load use", KIND_LOAD);
        run_test("branches", KIND_BRANCH);
        run_test("store order", KIND_STORE);
        run_test("mixed program", KIND_MIX);
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/pcpu_core.sv ====
// pcpu five-stage pipeline core
`timescale 1ns/10ps
`default_nettype none
`include "pcpu_cfg.svh"

module pcpu_core (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic [`PCPU_RADDR_W-1:0] reg_addr,   // debug read where 0 selects the pc
    output logic [`PCPU_XLEN-1:0]         reg_data,
    output logic [`PCPU_XLEN-1:0]         im_addr,
    input  wire logic [`PCPU_XLEN-1:0]    im_data,
    output logic [`PCPU_XLEN-1:0]         dm_addr,
    output logic                          dm_we,
    output logic [`PCPU_XLEN-1:0]         dm_wdata,
    input  wire logic [`PCPU_XLEN-1:0]    dm_rdata
);

    pcpu_pipe_pkg::hazard_t hz;
    pcpu_pipe_pkg::de_t     de;
    pcpu_pipe_pkg::em_t     em;
    pcpu_pipe_pkg::mw_t     mw;
    pcpu_isa_pkg::ctrl_t    ctrl_d;

    logic                  pc_src_d;
    logic [`PCPU_XLEN-1:0] pc_branch_d;
    logic [`PCPU_XLEN-1:0] wd_w;

    // **************************************************
    // fetch
    // **************************************************

    logic [`PCPU_XLEN-1:0] pc_f;
    logic [`PCPU_XLEN-1:0] pc_next_f;
    logic [`PCPU_XLEN-1:0] pc_next_d;
    logic [`PCPU_XLEN-1:0] instr_d;

    assign pc_next_f = pc_f + 1'b1;  // word addressed
    assign im_addr   = pc_f;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pc_f <= `PCPU_RESET_PC;
        else if (!hz.stall)
            pc_f <= pc_src_d ? pc_branch_d : pc_next_f;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_d <= '0;
        end else if (!hz.stall) begin
            instr_d <= pc_src_d ? '0 : im_data;  // squash the slot behind a taken branch
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.stall)
            pc_next_d <= pc_next_f;
    end

    // **************************************************
    // decode and register read
    // **************************************************

    logic [`PCPU_RADDR_W-1:0] rs_d;
    logic [`PCPU_RADDR_W-1:0] rt_d;
    logic [`PCPU_RADDR_W-1:0] rd_d;
    logic [`PCPU_XLEN-1:0]    imm_d;
    logic [`PCPU_XLEN-1:0]    rd1_d;
    logic [`PCPU_XLEN-1:0]    rd2_d;
    logic [`PCPU_XLEN-1:0]    rdbg_data;
    logic [`PCPU_XLEN-1:0]    cmp_a_d;
    logic [`PCPU_XLEN-1:0]    cmp_b_d;

    assign rs_d  = instr_d[25:21];
    assign rt_d  = instr_d[20:16];
    assign rd_d  = instr_d[15:11];
    assign imm_d = {{(`PCPU_XLEN-16){instr_d[15]}}, instr_d[15:0]};

    pcpu_regfile u_regfile (
        .clk       (clk),
        .ra1       (rs_d),
        .ra2       (rt_d),
        .rdbg      (reg_addr),
        .rd1       (rd1_d),
        .rd2       (rd2_d),
        .rdbg_data (rdbg_data),
        .wa        (mw.dst),
        .wd        (wd_w),
        .we        (mw.reg_write)
    );

    assign reg_data = (reg_addr != '0) ? rdbg_data : pc_f;

    // early branch compare with operands forwarded from memory
    assign cmp_a_d     = hz.fwd_a_d ? em.alu_result : rd1_d;
    assign cmp_b_d     = hz.fwd_b_d ? em.alu_result : rd2_d;
    assign pc_branch_d = pc_next_d + imm_d;

    pcpu_decode u_decode (
        .instr  (instr_d),
        .equal  (cmp_a_d == cmp_b_d),
        .ctrl   (ctrl_d),
        .pc_src (pc_src_d)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            de <= '0;
        else if (hz.flush_e)
            de <= '0;  // bubble
        else
            de <= '{rd1: rd1_d, rd2: rd2_d, imm: imm_d, rs: rs_d, rt: rt_d, rd: rd_d,
                    ctrl: ctrl_d};
    end

    // **************************************************
    // execute
    // **************************************************

    logic [`PCPU_XLEN-1:0]    src_a_e;
    logic [`PCPU_XLEN-1:0]    store_e;
    logic [`PCPU_XLEN-1:0]    alu_result_e;
    logic [`PCPU_RADDR_W-1:0] dst_e;

    function automatic logic [`PCPU_XLEN-1:0] fwd_mux(input pcpu_pipe_pkg::fwd_e sel,
                                                      input logic [`PCPU_XLEN-1:0] rf_val,
                                                      input logic [`PCPU_XLEN-1:0] mem_val,
                                                      input logic [`PCPU_XLEN-1:0] wb_val);
        case (sel)
            pcpu_pipe_pkg::FWD_MEM: return mem_val;
            pcpu_pipe_pkg::FWD_WB:  return wb_val;
            default:                return rf_val;
        endcase
    endfunction

    assign src_a_e = fwd_mux(hz.fwd_a_e, de.rd1, em.alu_result, wd_w);
    assign store_e = fwd_mux(hz.fwd_b_e, de.rd2, em.alu_result, wd_w);  // also sw data
    assign dst_e   = de.ctrl.reg_dst ? de.rd : de.rt;

    pcpu_alu u_alu (
        .a      (src_a_e),
        .b      (de.ctrl.alu_src ? de.imm : store_e),
        .op     (de.ctrl.alu_op),
        .result (alu_result_e)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            em <= '0;
        else
            em <= '{alu_result: alu_result_e, store_data: store_e, dst: dst_e,
                    reg_write: de.ctrl.reg_write, mem_write: de.ctrl.mem_write,
                    mem_to_reg: de.ctrl.mem_to_reg};
    end

    // **************************************************
    // memory
    // **************************************************

    assign dm_addr  = em.alu_result;
    assign dm_we    = em.mem_write;
    assign dm_wdata = em.store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mw <= '0;
        else
            mw <= '{alu_result: em.alu_result, read_data: dm_rdata, dst: em.dst,
                    reg_write: em.reg_write, mem_to_reg: em.mem_to_reg};
    end

    // **************************************************
    // writeback and hazards
    // **************************************************

    assign wd_w = mw.mem_to_reg ? mw.read_data : mw.alu_result;

    pcpu_hazard u_hazard (
        .rs_d         (rs_d),
        .rt_d         (rt_d),
        .rs_e         (de.rs),
        .rt_e         (de.rt),
        .dst_e        (dst_e),
        .dst_m        (em.dst),
        .dst_w        (mw.dst),
        .branch_d     (ctrl_d.branch),
        .reg_write_e  (de.ctrl.reg_write),
        .mem_to_reg_e (de.ctrl.mem_to_reg),
        .reg_write_m  (em.reg_write),
        .mem_to_reg_m (em.mem_to_reg),
        .reg_write_w  (mw.reg_write),
        .hz           (hz)
    );

endmodule

`default_nettype wire

// ==== src/pcpu_hazard.sv ====
// pcpu hazard unit
`timescale 1ns/10ps
`default_nettype none
`include "pcpu_cfg.svh"

module pcpu_hazard (
    input  wire logic [`PCPU_RADDR_W-1:0] rs_d,
    input  wire logic [`PCPU_RADDR_W-1:0] rt_d,
    input  wire logic [`PCPU_RADDR_W-1:0] rs_e,
    input  wire logic [`PCPU_RADDR_W-1:0] rt_e,
    input  wire logic [`PCPU_RADDR_W-1:0] dst_e,
    input  wire logic [`PCPU_RADDR_W-1:0] dst_m,
    input  wire logic [`PCPU_RADDR_W-1:0] dst_w,
    input  wire logic                     branch_d,
    input  wire logic                     reg_write_e,
    input  wire logic                     mem_to_reg_e,
    input  wire logic                     reg_write_m,
    input  wire logic                     mem_to_reg_m,
    input  wire logic                     reg_write_w,
    output pcpu_pipe_pkg::hazard_t        hz
);

    logic load_stall;
    logic branch_stall;

    // newest producer wins, $0 never forwarded
    function automatic pcpu_pipe_pkg::fwd_e fwd_src(input logic [`PCPU_RADDR_W-1:0] src);
        if (src == '0)
            return pcpu_pipe_pkg::FWD_NONE;
        else if (reg_write_m && src == dst_m)
            return pcpu_pipe_pkg::FWD_MEM;
        else if (reg_write_w && src == dst_w)
            return pcpu_pipe_pkg::FWD_WB;
        return pcpu_pipe_pkg::FWD_NONE;
    endfunction

    // load in execute feeding decode
    assign load_stall = mem_to_reg_e && (rs_d == dst_e || rt_d == dst_e);

    // branch operand not ready for the decode compare
    assign branch_stall = branch_d &&
        ((reg_write_e && (rs_d == dst_e || rt_d == dst_e)) ||
         (mem_to_reg_m && (rs_d == dst_m || rt_d == dst_m)));

    always_comb begin
        hz.stall   = load_stall | branch_stall;
        hz.flush_e = hz.stall;
        hz.fwd_a_e = fwd_src(rs_e);
        hz.fwd_b_e = fwd_src(rt_e);
        hz.fwd_a_d = (rs_d != '0) && reg_write_m && (rs_d == dst_m);
        hz.fwd_b_d = (rt_d != '0) && reg_write_m && (rt_d == dst_m);
    end

endmodule

`default_nettype wire

// ==== src/pcpu_regfile.sv ====
// pcpu register file
`timescale 1ns/10ps
`default_nettype none
`include "pcpu_cfg.svh"

module pcpu_regfile (
    input  wire logic                     clk,
    input  wire logic [`PCPU_RADDR_W-1:0] ra1,
    input  wire logic [`PCPU_RADDR_W-1:0] ra2,
    input  wire logic [`PCPU_RADDR_W-1:0] rdbg,
    output logic [`PCPU_XLEN-1:0]         rd1,
    output logic [`PCPU_XLEN-1:0]         rd2,
    output logic [`PCPU_XLEN-1:0]         rdbg_data,
    input  wire logic [`PCPU_RADDR_W-1:0] wa,
    input  wire logic [`PCPU_XLEN-1:0]    wd,
    input  wire logic                     we
);

    logic [`PCPU_XLEN-1:0] regs [2**`PCPU_RADDR_W];

    // written on the falling edge so decode reads it in the same cycle
    always_ff @(negedge clk) begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

    // $0 is hardwired to zero
    assign rd1       = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2       = (ra2 == '0) ? '0 : regs[ra2];
    assign rdbg_data = (rdbg == '0) ? '0 : regs[rdbg];

endmodule

`default_nettype wire

// ==== src/pcpu_alu.sv ====
// pcpu execute ALU
`timescale 1ns/10ps
`default_nettype none
`include "pcpu_cfg.svh"

module pcpu_alu (
    input  wire logic [`PCPU_XLEN-1:0] a,
    input  wire logic [`PCPU_XLEN-1:0] b,
    input  wire pcpu_isa_pkg::alu_op_e op,
    output logic [`PCPU_XLEN-1:0]      result
);

    always_comb begin
        case (op)
            pcpu_isa_pkg::ALU_ADD: result = a + b;
            pcpu_isa_pkg::ALU_SUB: result = a - b;
            pcpu_isa_pkg::ALU_AND: result = a & b;
            pcpu_isa_pkg::ALU_OR:  result = a | b;
            pcpu_isa_pkg::ALU_SLT: begin
                result = '0;
                result[0] = $signed(a) < $signed(b);
            end
            // immediate to the upper half
            pcpu_isa_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
            default:               result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/pcpu_decode.sv ====
// pcpu control unit
`timescale 1ns/10ps
`default_nettype none
`include "pcpu_cfg.svh"

module pcpu_decode (
    input  wire logic [`PCPU_XLEN-1:0] instr,
    input  wire logic                  equal,   // early compare of rs and rt
    output pcpu_isa_pkg::ctrl_t        ctrl,
    output logic                       pc_src   // take the branch
);

    always_comb begin
        ctrl = '0;  // no-op unless recognised
        case (instr[31:26])
            pcpu_isa_pkg::OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (instr[5:0])
                    pcpu_isa_pkg::FN_ADDU: ctrl.alu_op = pcpu_isa_pkg::ALU_ADD;
                    pcpu_isa_pkg::FN_SUBU: ctrl.alu_op = pcpu_isa_pkg::ALU_SUB;
                    pcpu_isa_pkg::FN_AND:  ctrl.alu_op = pcpu_isa_pkg::ALU_AND;
                    pcpu_isa_pkg::FN_OR:   ctrl.alu_op = pcpu_isa_pkg::ALU_OR;
                    pcpu_isa_pkg::FN_SLT:  ctrl.alu_op = pcpu_isa_pkg::ALU_SLT;
                    default:               ctrl = '0;
                endcase
            end
            pcpu_isa_pkg::OP_ADDIU: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = pcpu_isa_pkg::ALU_ADD;
            end
            pcpu_isa_pkg::OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = pcpu_isa_pkg::ALU_LUI;
            end
            pcpu_isa_pkg::OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            pcpu_isa_pkg::OP_SW: begin
                ctrl.alu_src   = 1'b1;  // address = rs + imm
                ctrl.mem_write = 1'b1;
            end
            pcpu_isa_pkg::OP_BEQ: ctrl.branch = 1'b1;
            pcpu_isa_pkg::OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // beq taken on equal, bne on not equal
    assign pc_src = ctrl.branch & (ctrl.branch_ne ^ equal);

endmodule

`default_nettype wire

// ==== src/pcpu_pipe_pkg.sv ====
// pcpu pipeline register types
`default_nettype none
`include "pcpu_cfg.svh"

package pcpu_pipe_pkg;

    // execute operand source
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,  // alu result in memory stage
        FWD_WB   = 2'd2   // writeback data
    } fwd_e;

    // decode -> execute
    typedef struct packed {
        logic [`PCPU_XLEN-1:0]    rd1;
        logic [`PCPU_XLEN-1:0]    rd2;
        logic [`PCPU_XLEN-1:0]    imm;  // sign extended
        logic [`PCPU_RADDR_W-1:0] rs;
        logic [`PCPU_RADDR_W-1:0] rt;
        logic [`PCPU_RADDR_W-1:0] rd;
        pcpu_isa_pkg::ctrl_t      ctrl;
    } de_t;

    // execute -> memory
    typedef struct packed {
        logic [`PCPU_XLEN-1:0]    alu_result;
        logic [`PCPU_XLEN-1:0]    store_data;
        logic [`PCPU_RADDR_W-1:0] dst;
        logic                     reg_write;
        logic                     mem_write;
        logic                     mem_to_reg;
    } em_t;

    // memory -> writeback
    typedef struct packed {
        logic [`PCPU_XLEN-1:0]    alu_result;
        logic [`PCPU_XLEN-1:0]    read_data;
        logic [`PCPU_RADDR_W-1:0] dst;
        logic                     reg_write;
        logic                     mem_to_reg;
    } mw_t;

    typedef struct packed {
        logic stall;    // hold fetch and decode
        logic flush_e;  // bubble into execute
        fwd_e fwd_a_e;
        fwd_e fwd_b_e;
        logic fwd_a_d;  // branch compare from memory stage
        logic fwd_b_d;
    } hazard_t;

endpackage

`default_nettype wire

// ==== src/pcpu_isa_pkg.sv ====
// pcpu instruction set types
`default_nettype none

package pcpu_isa_pkg;

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;   // write rf in writeback
        logic    reg_dst;     // dest is rd, else rt
        logic    alu_src;     // alu b from immediate
        alu_op_e alu_op;
        logic    mem_write;
        logic    mem_to_reg;  // load result to rf
        logic    branch;
        logic    branch_ne;   // bne, else beq
    } ctrl_t;

endpackage

`default_nettype wire

// ==== src/pcpu_cfg.svh ====
// pcpu core configuration
`ifndef PCPU_CFG_SVH
`define PCPU_CFG_SVH

// data and address width
`define PCPU_XLEN 32

// register index width, 32 registers
`define PCPU_RADDR_W 5

// first fetch address after reset, in words
`define PCPU_RESET_PC 32'h0000_0000

`endif
